//--- files.f
common/qla_pkg.sv
verilog/axil_host_port.sv
verilog/rt_block_writer.sv
verilog/write_bus_stage.sv
motor/motor_channel.sv
motor/dac_update.sv
verilog/qla_regs_top.sv
dv/qla_tb_assert.sv
dv/qla_tb.sv

//--- Bender.yml
package:
  name: qla_regs

sources:
  - common/qla_pkg.sv
  - verilog/axil_host_port.sv
  - verilog/rt_block_writer.sv
  - verilog/write_bus_stage.sv
  - motor/motor_channel.sv
  - motor/dac_update.sv
  - verilog/qla_regs_top.sv
  - target: test
    files:
      - dv/qla_tb_assert.sv
      - dv/qla_tb.sv

//--- dv/qla_tb.sv
`default_nettype none

module qla_tb import qla_pkg::*; ();

    localparam int wait_max = 2000;  // cycles, any single wait

    logic                   sysclk = 1'b0;
    logic                   rst_n;
    logic [3:0]             wenid, s_wstrb, rt_waddr;
    logic [addr_w-1:0]      s_awaddr, s_araddr;
    logic [data_w-1:0]      s_wdata, s_rdata;
    logic [1:0]             s_bresp, s_rresp;
    logic                   s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready, rt_wen;
    logic                   s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
    logic [cur_w-1:0]       rt_wdata;
    logic [num_chan-1:0]    amp_disable_pin;
    logic                   dac_sclk, dac_mosi, dac_csn;

    logic [cur_w-1:0]       exp_cur [1:num_chan];  // model of commanded currents
    logic [num_chan-1:0]    exp_en;                // model of amp enables, chan 1 in bit 0
    logic [31:0]            rng = 32'h336a;
    logic [dac_frame_w-1:0] frame_q [$];           // frames seen on the dac pins
    logic [dac_frame_w-1:0] frame_sr;
    int                     frame_bits;

    always #10 sysclk = ~sysclk;

    qla_regs_top i_dut (.*);

    // ------------------------------
    // dac pin monitor
    // ------------------------------
    always @(negedge sysclk) begin
        if (dac_csn) begin
            frame_bits = 0;
        end else if (dac_sclk) begin  // bit stable while sclk high
            frame_sr   = {frame_sr[dac_frame_w-2:0], dac_mosi};
            frame_bits = frame_bits + 1;
            if (frame_bits == dac_frame_w) begin
                frame_q.push_back(frame_sr);
                frame_bits = 0;
            end
        end
    end

    // bound checker failures end the run at once
    always @(negedge sysclk) begin
        if (i_dut.i_chk.assert_errors != 0) begin
            stop_on_error("a protocol assertion in the bound checker failed");
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // main space, chan in bits 7:4, offset in bits 3:0
    function automatic logic [addr_w-1:0] chan_addr(input int ch, input logic [3:0] off);
        return {4'h0, 4'h0, 4'(ch), off};
    endfunction

    task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        int n;
        @(negedge sysclk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge sysclk);
            n++;
            if (n > wait_max) stop_on_error("host write got no response in time");
        end while (!s_bvalid);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        assert (s_bresp == 2'b00) else stop_on_error($sformatf("ERR s_bresp got %h exp 0", s_bresp));
        rng = lcg_next(rng);
        repeat (rng[9:8]) @(negedge sysclk);  // bready late now and then
        s_bready = 1'b1;
        @(negedge sysclk);
        s_bready = 1'b0;
    endtask

    task automatic read_check(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp);
        int n;
        @(negedge sysclk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        assert (s_arready) else stop_on_error($sformatf("ERR s_arready got %h exp 1", s_arready));
        n = 0;
        do begin
            @(negedge sysclk);
            n++;
            if (n > wait_max) stop_on_error("host read returned no data in time");
        end while (!s_rvalid);
        s_arvalid = 1'b0;
        assert (s_rdata == exp)
            else stop_on_error($sformatf("ERR s_rdata addr %h got %h exp %h", addr, s_rdata, exp));
        assert (s_rresp == 2'b00) else stop_on_error($sformatf("ERR s_rresp got %h exp 0", s_rresp));
        assert (!s_arready) else stop_on_error($sformatf("ERR s_arready got %h exp 0", s_arready));
        s_rready = 1'b1;
        @(negedge sysclk);
        s_rready = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (i_dut.dac_busy !== level) begin
            @(negedge sysclk);
            n++;
            if (n > wait_max) stop_on_error("dac_busy never reached the expected level");
        end
    endtask

    task automatic check_frames();
        logic [dac_frame_w-1:0] exp_frame;
        logic [dac_frame_w-1:0] got_frame;
        int n;
        n = 0;
        while (frame_q.size() < num_chan) begin
            @(negedge sysclk);
            n++;
            if (n > wait_max) stop_on_error("too few DAC frames on the pins");
        end
        for (int ch = 1; ch <= num_chan; ch++) begin
            got_frame = frame_q.pop_front();
            exp_frame = {dac_cmd, 4'(ch - 1), exp_cur[ch]};  // cmd, index, current
            assert (got_frame == exp_frame) else stop_on_error($sformatf(
                "ERR dac_mosi frame chan %0d got %h exp %h", ch, got_frame, exp_frame));
        end
    endtask

    task automatic send_block();
        for (int i = 0; i < num_chan; i++) begin
            @(negedge sysclk);
            rt_wen   = 1'b1;
            rt_waddr = 4'(i);
            rt_wdata = exp_cur[i+1];
        end
        @(negedge sysclk);
        rt_wen = 1'b0;
    endtask

    initial begin
        {rst_n, s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready, rt_wen} = '0;
        {s_awaddr, s_araddr, s_wdata, s_wstrb, rt_waddr, rt_wdata} = '0;
        wenid = 4'h5;
        repeat (8) @(negedge sysclk);
        rst_n = 1'b1;

        // ------------------------------
        // host currents, board id, amp enables
        // ------------------------------
        for (int ch = 1; ch <= num_chan; ch++) begin
            rng = lcg_next(rng);
            exp_cur[ch] = rng[31:16];
            host_write(chan_addr(ch, off_dac_ctrl), {rng[15:0], exp_cur[ch]});  // upper half junk
            rng = lcg_next(rng);
            exp_en[ch-1] = rng[24];
            host_write(chan_addr(ch, off_amp_ctrl), data_w'(exp_en[ch-1]));
        end
        for (int ch = 1; ch <= num_chan; ch++) begin
            read_check(chan_addr(ch, off_dac_ctrl), data_w'(exp_cur[ch]));
            read_check(chan_addr(ch, off_amp_ctrl), data_w'(exp_en[ch-1]));
        end
        read_check(chan_addr(0, off_status), {28'd0, ~wenid});
        assert (amp_disable_pin == ~exp_en) else stop_on_error($sformatf(
            "ERR amp_disable_pin got %h exp %h", amp_disable_pin, ~exp_en));

        // host dac update, second request while busy
        frame_q.delete();
        host_write(chan_addr(0, off_dac_ctrl), '0);
        wait_busy(1'b1);
        read_check(chan_addr(0, off_status), {23'd0, 1'b1, 4'd0, ~wenid});
        host_write(chan_addr(0, off_dac_ctrl), '0);
        check_frames();
        check_frames();
        wait_busy(1'b0);
        repeat (4) @(negedge sysclk);
        assert (!i_dut.dac_busy && frame_q.size() == 0)
            else stop_on_error("an extra DAC transfer followed the queued request");

        // real-time block, host write held off during the replay
        for (int ch = 1; ch <= num_chan; ch++) begin
            rng = lcg_next(rng);
            exp_cur[ch] = rng[31:16];
        end
        fork
            send_block();
            begin
                repeat (4) @(negedge sysclk);
                exp_en[0] = ~exp_en[0];
                host_write(chan_addr(1, off_amp_ctrl), data_w'(exp_en[0]));
            end
        join
        check_frames();
        wait_busy(1'b0);
        for (int ch = 1; ch <= num_chan; ch++) begin
            read_check(chan_addr(ch, off_dac_ctrl), data_w'(exp_cur[ch]));
        end
        read_check(chan_addr(1, off_amp_ctrl), data_w'(exp_en[0]));  // held-off write landed
        assert (amp_disable_pin == ~exp_en) else stop_on_error($sformatf(
            "ERR amp_disable_pin got %h exp %h", amp_disable_pin, ~exp_en));

        repeat (4) @(negedge sysclk);
        if (i_dut.i_chk.assert_errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_on_error("a protocol assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

//--- dv/qla_tb_assert.sv
`default_nettype none

module qla_tb_assert (
    input wire sysclk,
    input wire rst_n,
    input wire s_awready,
    input wire s_wready,
    input wire s_bvalid,
    input wire s_bready,
    input wire s_rvalid,
    input wire s_rready,
    input wire rt_active,
    input wire blk_wen,
    input wire dac_busy,
    input wire dac_pending,  // queued dac request
    input wire dac_csn
);

    int assert_errors = 0;  // failures so far

    // ------------------------------
    // host handshake
    // ------------------------------
    a_bvalid_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid)
        else begin
            $error("bvalid dropped before bready");
            assert_errors++;
        end

    a_rvalid_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid)
        else begin
            $error("rvalid dropped before rready");
            assert_errors++;
        end

    a_no_wr_rt: assert property (@(posedge sysclk) disable iff (!rst_n)
        rt_active |-> !s_awready && !s_wready)  // block replay owns the bus
        else begin
            $error("host write accepted during block replay");
            assert_errors++;
        end

    // ------------------------------
    // dac request and transfer
    // ------------------------------
    a_reset_idle: assert property (@(posedge sysclk)
        $rose(rst_n) |-> dac_csn && !dac_busy)
        else begin
            $error("dac not idle after reset");
            assert_errors++;
        end

    a_busy_req: assert property (@(posedge sysclk) disable iff (!rst_n)
        dac_busy && blk_wen |=> dac_pending)
        else begin
            $error("request during transfer was lost");
            assert_errors++;
        end

    a_req_starts: assert property (@(posedge sysclk) disable iff (!rst_n)
        !dac_busy && dac_pending |=> dac_busy)  // queued one starts right away
        else begin
            $error("queued request did not start a transfer");
            assert_errors++;
        end

    a_one_xfer: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(dac_busy) |-> $past(dac_pending) && dac_pending == $past(blk_wen))
        else begin
            $error("transfer count does not match requests");
            assert_errors++;
        end

endmodule

bind qla_regs_top qla_tb_assert i_chk (
    .sysclk, .rst_n, .s_awready, .s_wready, .s_bvalid, .s_bready,
    .s_rvalid, .s_rready, .rt_active, .blk_wen, .dac_busy, .dac_csn,
    .dac_pending (i_dac.pending)
);

`default_nettype wire

//--- verilog/qla_regs_top.sv
`default_nettype none

module qla_regs_top import qla_pkg::*; (
    input  wire                 sysclk,
    input  wire                 rst_n,
    input  wire [3:0]           wenid,            // rotary switch
    // axi4-lite host port
    input  wire [addr_w-1:0]    s_awaddr,
    input  wire                 s_awvalid,
    output logic                s_awready,
    input  wire [data_w-1:0]    s_wdata,
    input  wire [3:0]           s_wstrb,
    input  wire                 s_wvalid,
    output logic                s_wready,
    output logic                s_bvalid,
    output logic [1:0]          s_bresp,
    input  wire                 s_bready,
    input  wire [addr_w-1:0]    s_araddr,
    input  wire                 s_arvalid,
    output logic                s_arready,
    output logic                s_rvalid,
    output logic [data_w-1:0]   s_rdata,
    output logic [1:0]          s_rresp,
    input  wire                 s_rready,
    // real-time block
    input  wire                 rt_wen,
    input  wire [3:0]           rt_waddr,
    input  wire [cur_w-1:0]     rt_wdata,
    // board pins
    output logic [num_chan-1:0] amp_disable_pin,
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csn
);

    // ------------------------------
    // write bus sources and result
    // ------------------------------
    logic                      h_wen;
    logic [addr_w-1:0]         h_waddr;
    logic [data_w-1:0]         h_wdata;
    logic                      h_blk;
    logic                      b_wen;
    logic [addr_w-1:0]         b_waddr;
    logic [data_w-1:0]         b_wdata;
    logic                      b_blk;
    logic                      rt_active;    // 1 -> block writer drives the bus
    logic                      reg_wen;
    logic [addr_w-1:0]         reg_waddr;
    logic [data_w-1:0]         reg_wdata;
    logic                      blk_wen;      // dac update request
    logic [num_chan*cur_w-1:0] cur_cmd_all;  // chan 1 in the low bits
    logic [num_chan-1:0]       amp_en_all;
    logic                      dac_busy;

    axil_host_port i_host (
        .sysclk, .rst_n,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
        .s_bvalid, .s_bresp, .s_bready,
        .s_araddr, .s_arvalid, .s_arready, .s_rvalid, .s_rdata, .s_rresp, .s_rready,
        .wenid, .rt_active, .cur_cmd_all, .amp_en_all, .dac_busy,
        .h_wen, .h_waddr, .h_wdata, .h_blk
    );

    rt_block_writer i_rt_write (
        .sysclk, .rst_n, .rt_wen, .rt_waddr, .rt_wdata,
        .rt_active, .b_wen, .b_waddr, .b_wdata, .b_blk
    );

    write_bus_stage i_wbus (
        .sysclk, .rst_n, .rt_active,
        .h_wen, .h_waddr, .h_wdata, .h_blk,
        .b_wen, .b_waddr, .b_wdata, .b_blk,
        .reg_wen, .reg_waddr, .reg_wdata, .blk_wen
    );

    // one register set per axis
    generate
        for (genvar k = 1; k <= num_chan; k++) begin : g_chan
            motor_channel #(.CHANNEL(k)) i_motor (
                .sysclk, .rst_n, .reg_wen, .reg_waddr, .reg_wdata,
                .cur_cmd         (cur_cmd_all[(k-1)*cur_w +: cur_w]),
                .amp_en          (amp_en_all[k-1]),
                .amp_disable_pin (amp_disable_pin[k-1])
            );
        end
    endgenerate

    dac_update i_dac (
        .sysclk, .rst_n, .blk_wen, .cur_cmd_all,
        .dac_busy, .dac_sclk, .dac_mosi, .dac_csn
    );

endmodule

`default_nettype wire

//--- motor/dac_update.sv
`default_nettype none

module dac_update import qla_pkg::*; (
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire                      blk_wen,      // update request beat
    input  wire [num_chan*cur_w-1:0] cur_cmd_all,
    output logic                     dac_busy,
    output logic                     dac_sclk,     // sysclk / 2
    output logic                     dac_mosi,
    output logic                     dac_csn
);

    logic                      pending;    // request not yet served
    logic                      start;
    logic [num_chan*cur_w-1:0] snap;       // currents at start
    logic [dac_frame_w-1:0]    shreg;
    logic [dac_cnt_w-1:0]      bit_cnt;
    logic [1:0]                frame_idx;
    logic [1:0]                next_idx;

    // command, channel index, current
    function automatic logic [dac_frame_w-1:0] make_frame(input logic [1:0]       idx,
                                                          input logic [cur_w-1:0] cur);
        return {dac_cmd, 2'b00, idx, cur};
    endfunction

    assign start    = pending & ~dac_busy;
    assign next_idx = frame_idx + 2'd1;
    assign dac_mosi = shreg[dac_frame_w-1];  // msb first

    // a request during a transfer waits for the next one
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= blk_wen | (pending & ~start);
        end
    end

    // ------------------------------
    // frame shifter
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_busy  <= 1'b0;
            dac_csn   <= 1'b1;
            dac_sclk  <= 1'b0;
            shreg     <= '0;
            bit_cnt   <= '0;
            frame_idx <= '0;
        end else if (start) begin
            dac_busy  <= 1'b1;
            dac_csn   <= 1'b0;
            dac_sclk  <= 1'b0;
            shreg     <= make_frame(2'd0, cur_cmd_all[cur_w-1:0]);
            bit_cnt   <= '0;
            frame_idx <= '0;
        end else if (dac_busy && !dac_csn) begin
            dac_sclk <= ~dac_sclk;
            if (dac_sclk) begin                   // falling sclk, next bit out
                shreg   <= shreg << 1;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == dac_cnt_w'(dac_frame_w - 1)) begin
                    dac_csn <= 1'b1;              // frame done
                end
            end
        end else if (dac_busy) begin
            // one cycle with csn high between frames
            if (frame_idx == 2'(num_chan - 1)) begin
                dac_busy <= 1'b0;
            end else begin
                frame_idx <= next_idx;
                dac_csn   <= 1'b0;
                bit_cnt   <= '0;
                shreg     <= make_frame(next_idx, snap[next_idx*cur_w +: cur_w]);
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (start) begin
            snap <= cur_cmd_all;  // frames 2..4 come from here
        end
    end

endmodule

`default_nettype wire

//--- motor/motor_channel.sv
`default_nettype none

module motor_channel import qla_pkg::*; #(
    parameter int CHANNEL = 1  // axis number, 1..num_chan
) (
    input  wire               sysclk,
    input  wire               rst_n,
    input  wire               reg_wen,
    input  wire [addr_w-1:0]  reg_waddr,
    input  wire [data_w-1:0]  reg_wdata,
    output logic [cur_w-1:0]  cur_cmd,          // commanded current
    output logic              amp_en,           // host enable
    output logic              amp_disable_pin   // active high to the amplifier
);

    logic chan_hit;
    logic wr_cur;
    logic wr_amp;

    // ------------------------------
    // write decode
    // ------------------------------
    assign chan_hit = reg_wen && addr_space(reg_waddr) == addr_main
                      && addr_chan(reg_waddr) == fld_w'(CHANNEL);
    assign wr_cur = chan_hit && addr_off(reg_waddr) == off_dac_ctrl;
    assign wr_amp = chan_hit && addr_off(reg_waddr) == off_amp_ctrl;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= '0;
            amp_en  <= 1'b0;
        end else begin
            if (wr_cur) begin
                cur_cmd <= reg_wdata[cur_w-1:0];  // low half only
            end
            if (wr_amp) begin
                amp_en <= reg_wdata[0];
            end
        end
    end

    // pin is the registered inverse, amps off out of reset
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_disable_pin <= 1'b1;
        end else begin
            amp_disable_pin <= ~amp_en;
        end
    end

endmodule

`default_nettype wire

//--- verilog/write_bus_stage.sv
`default_nettype none

module write_bus_stage import qla_pkg::*; (
    input  wire               sysclk,
    input  wire               rst_n,
    input  wire               rt_active,  // 1 -> block writer drives
    // host beat
    input  wire               h_wen,
    input  wire [addr_w-1:0]  h_waddr,
    input  wire [data_w-1:0]  h_wdata,
    input  wire               h_blk,
    // block writer beat
    input  wire               b_wen,
    input  wire [addr_w-1:0]  b_waddr,
    input  wire [data_w-1:0]  b_wdata,
    input  wire               b_blk,
    // shared write bus
    output logic              reg_wen,
    output logic [addr_w-1:0] reg_waddr,
    output logic [data_w-1:0] reg_wdata,
    output logic              blk_wen
);

    // ------------------------------
    // source select and register
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wen <= 1'b0;
            blk_wen <= 1'b0;
        end else begin
            reg_wen <= rt_active ? b_wen : h_wen;
            blk_wen <= rt_active ? b_blk : h_blk;
        end
    end

    // address and data follow the same select
    always_ff @(posedge sysclk) begin
        reg_waddr <= rt_active ? b_waddr : h_waddr;
        reg_wdata <= rt_active ? b_wdata : h_wdata;
    end

endmodule

`default_nettype wire

//--- verilog/rt_block_writer.sv
`default_nettype none

module rt_block_writer import qla_pkg::*; (
    input  wire               sysclk,
    input  wire               rst_n,
    input  wire               rt_wen,     // one word per strobe
    input  wire [3:0]         rt_waddr,   // index 0..3 = chan 1..4
    input  wire [cur_w-1:0]   rt_wdata,
    output logic              rt_active,  // replay owns the write bus
    output logic              b_wen,
    output logic [addr_w-1:0] b_waddr,
    output logic [data_w-1:0] b_wdata,
    output logic              b_blk
);

    logic [cur_w-1:0] blk_buf [num_chan];  // one current per axis
    logic [1:0]       slot;                // replay position
    logic             blk_last;            // strobe of the last word

    assign blk_last = rt_wen && rt_waddr == 4'(num_chan - 1);

    // block buffer, out-of-range indexes dropped
    always_ff @(posedge sysclk) begin
        if (rt_wen && rt_waddr < num_chan) begin
            blk_buf[rt_waddr[1:0]] <= rt_wdata;
        end
    end

    // ------------------------------
    // replay counter
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            rt_active <= 1'b0;
            slot      <= '0;
        end else if (blk_last) begin
            rt_active <= 1'b1;  // a newer block restarts the replay
            slot      <= '0;
        end else if (rt_active) begin
            slot <= slot + 2'd1;
            if (slot == 2'(num_chan - 1)) begin
                rt_active <= 1'b0;
            end
        end
    end

    // one current write per cycle, chan 1 first
    assign b_wen   = rt_active;
    assign b_waddr = make_addr({2'b00, slot} + 4'd1, off_dac_ctrl);
    assign b_wdata = data_w'(blk_buf[slot]);
    assign b_blk   = rt_active && slot == 2'(num_chan - 1);  // last beat asks for dac update

endmodule

`default_nettype wire

//--- verilog/axil_host_port.sv
`default_nettype none

module axil_host_port import qla_pkg::*; (
    input  wire                      sysclk,
    input  wire                      rst_n,
    // axi4-lite write
    input  wire [addr_w-1:0]         s_awaddr,
    input  wire                      s_awvalid,
    output logic                     s_awready,
    input  wire [data_w-1:0]         s_wdata,
    input  wire [3:0]                s_wstrb,
    input  wire                      s_wvalid,
    output logic                     s_wready,
    output logic                     s_bvalid,
    output logic [1:0]               s_bresp,
    input  wire                      s_bready,
    // axi4-lite read
    input  wire [addr_w-1:0]         s_araddr,
    input  wire                      s_arvalid,
    output logic                     s_arready,
    output logic                     s_rvalid,
    output logic [data_w-1:0]        s_rdata,
    output logic [1:0]               s_rresp,
    input  wire                      s_rready,
    // board state for readback
    input  wire [3:0]                wenid,        // rotary switch
    input  wire                      rt_active,    // block writer owns the bus
    input  wire [num_chan*cur_w-1:0] cur_cmd_all,
    input  wire [num_chan-1:0]       amp_en_all,
    input  wire                      dac_busy,
    // host side of the write bus
    output logic                     h_wen,
    output logic [addr_w-1:0]        h_waddr,
    output logic [data_w-1:0]        h_wdata,
    output logic                     h_blk
);

    logic              wr_accept;
    logic              rd_accept;
    logic              rd_main;
    logic [fld_w-1:0]  rd_chan;
    logic [fld_w-1:0]  rd_off;
    logic [1:0]        rd_idx;
    logic [data_w-1:0] rd_word;

    // ------------------------------
    // write channel
    // ------------------------------
    assign wr_accept = s_awvalid & s_wvalid & ~s_bvalid & ~rt_active;  // aw and w together
    assign s_awready = wr_accept;
    assign s_wready  = wr_accept;
    assign s_bresp   = 2'b00;  // always okay

    // beat goes straight to the write-bus stage
    assign h_wen   = wr_accept & (|s_wstrb);  // empty strobe is acked, no register change
    assign h_waddr = s_awaddr;
    assign h_wdata = s_wdata;
    assign h_blk   = h_wen && addr_space(s_awaddr) == addr_main
                     && addr_chan(s_awaddr) == '0 && addr_off(s_awaddr) == off_dac_ctrl;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            s_bvalid <= 1'b0;
        end else if (wr_accept) begin
            s_bvalid <= 1'b1;
        end else if (s_bready) begin
            s_bvalid <= 1'b0;  // held until master takes it
        end
    end

    // ------------------------------
    // read channel
    // ------------------------------
    assign s_arready = ~s_rvalid;  // one read in flight
    assign rd_accept = s_arvalid & s_arready;
    assign s_rresp   = 2'b00;

    assign rd_main = addr_space(s_araddr) == addr_main;
    assign rd_chan = addr_chan(s_araddr);
    assign rd_off  = addr_off(s_araddr);
    assign rd_idx  = rd_chan[1:0] - 2'd1;  // chan 1..4 -> slot 0..3

    // channel-number read select
    always_comb begin
        rd_word = '0;
        if (rd_main && rd_chan == '0 && rd_off == off_status) begin
            rd_word[3:0] = ~wenid;     // board id
            rd_word[8]   = dac_busy;
        end else if (rd_main && rd_chan >= 1 && rd_chan <= num_chan) begin
            if (rd_off == off_dac_ctrl)
                rd_word[cur_w-1:0] = cur_cmd_all[rd_idx*cur_w +: cur_w];
            else if (rd_off == off_amp_ctrl)
                rd_word[0] = amp_en_all[rd_idx];
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rd_accept) begin
            s_rdata <= rd_word;  // data valid with rvalid
        end
    end

endmodule

`default_nettype wire

//--- common/qla_pkg.sv
`default_nettype none

package qla_pkg;

    // ------------------------------
    // register bus geometry
    // ------------------------------
    localparam int addr_w   = 16;  // host register address
    localparam int data_w   = 32;  // host register data
    localparam int cur_w    = 16;  // commanded current
    localparam int num_chan = 4;   // motor axes on the board
    localparam int fld_w    = 4;   // space, channel and offset fields

    // address space, bits 15:12
    localparam logic [fld_w-1:0] addr_main = 4'd0;

    // offsets within a channel, bits 3:0
    localparam logic [fld_w-1:0] off_status   = 4'd0;  // chan 0 only
    localparam logic [fld_w-1:0] off_dac_ctrl = 4'd1;  // chan 0 here means dac update
    localparam logic [fld_w-1:0] off_amp_ctrl = 4'd2;  // enable in bit 0

    // ------------------------------
    // quad dac frame
    // ------------------------------
    localparam logic [3:0] dac_cmd     = 4'd3;                  // write and update
    localparam int         dac_frame_w = 24;                    // cmd, index, current
    localparam int         dac_cnt_w   = $clog2(dac_frame_w);   // bit counter

    // address field helpers
    function automatic logic [fld_w-1:0] addr_space(input logic [addr_w-1:0] a);
        return a[addr_w-1 -: fld_w];
    endfunction

    function automatic logic [fld_w-1:0] addr_chan(input logic [addr_w-1:0] a);
        return a[2*fld_w-1 -: fld_w];
    endfunction

    function automatic logic [fld_w-1:0] addr_off(input logic [addr_w-1:0] a);
        return a[fld_w-1:0];
    endfunction

    // main-space address of a channel register
    function automatic logic [addr_w-1:0] make_addr(input logic [fld_w-1:0] chan,
                                                    input logic [fld_w-1:0] off);
        return {addr_main, {(addr_w-3*fld_w){1'b0}}, chan, off};
    endfunction

endpackage

`default_nettype wire
